/* Bender.yml */
package:
  name: lmem

sources:
  - files:
      - hdl/lmem_pkg.sv
      - hdl/lmem_circ_fwd.sv
      - hdl/lmem_circ_bwd.sv
      - hdl/lmem_read_align.sv
      - hdl/lmem_top.sv
  - target: test
    files:
      - verification/lmem_tb.sv

/* hdl/lmem_circ_bwd.sv */
`default_nettype none

// layer 1 results and channel llrs of one circulant, read back in layer 0
module lmem_circ_bwd #(
  parameter int HAS_UNLOAD = 0  // 1 on systematic blocks
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         i_load_en,
  input  wire  [lmem_pkg::BLK_W-1:0]  i_load_data,
  input  wire                         i_wr_en,
  input  wire  [lmem_pkg::BLK_W-1:0]  i_wr_data,
  input  wire                         i_rd_en,
  input  wire  [lmem_pkg::ADDR_W-1:0] i_rd_address,
  input  wire                         i_unload_en,
  input  wire  [lmem_pkg::ADDR_W-1:0] i_unload_address,
  output logic [lmem_pkg::BLK_W-1:0]  o_rd_data,
  output logic [lmem_pkg::HD_W-1:0]   o_hd_data
);

  import lmem_pkg::*;

  logic [BLK_W-1:0]  mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;   // one pointer for load and layer 1 write
  logic              wr_any;
  logic [BLK_W-1:0]  wr_word;

  assign wr_any  = i_load_en | i_wr_en;
  assign wr_word = i_load_en ? i_load_data : i_wr_data;  // load wins, never both

  ////////////////////
  // write side

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
    end else if (wr_any) begin
      wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_any) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  ////////////////////
  // layer 0 read port

  always_ff @(posedge clk) begin
    if (!rst) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= mem[i_rd_address];
    end
  end

  ////////////////////
  // hard decision port

  if (HAS_UNLOAD != 0) begin : g_unload
    logic [BLK_W-1:0] ul_word;
    logic [HD_W-1:0]  sign_bits;

    assign ul_word = mem[i_unload_address];  // second read port
    for (genvar s = 0; s < R_SYM; s++) begin : g_sym
      assign sign_bits[s] = ul_word[s*LLR_W + LLR_W - 1];  // msb is the sign
    end

    always_ff @(posedge clk) begin
      if (!rst) begin
        o_hd_data <= '0;
      end else if (i_unload_en) begin
        o_hd_data <= sign_bits;
      end
    end
  end else begin : g_no_unload
    assign o_hd_data = '0;  // parity block
  end

  // the layer decode in the top and the load sequencer must not overlap
  a_load_wr_excl : assert property (@(posedge clk) disable iff (!rst)
    !(i_load_en && i_wr_en));

endmodule

`default_nettype wire

/* hdl/lmem_circ_fwd.sv */
`default_nettype none

// layer 0 results of one circulant, read back in layer 1
module lmem_circ_fwd (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         i_wr_en,
  input  wire  [lmem_pkg::BLK_W-1:0]  i_wr_data,
  input  wire                         i_rd_en,
  input  wire  [lmem_pkg::ADDR_W-1:0] i_rd_address,
  output logic [lmem_pkg::BLK_W-1:0]  o_rd_data
);

  import lmem_pkg::*;

  logic [BLK_W-1:0]  mem [DEPTH];  // plain queue, no shift pattern
  logic [ADDR_W-1:0] wr_ptr;

  ////////////////////
  // write side

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
    end else if (i_wr_en) begin
      // wrap after DEPTH words
      wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  ////////////////////
  // read side

  // same cycle write to the same address gives old word
  always_ff @(posedge clk) begin
    if (!rst) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= mem[i_rd_address];
    end  // holds between reads
  end

endmodule

`default_nettype wire

/* hdl/lmem_pkg.sv */
`default_nettype none

package lmem_pkg;

  ////////////////////
  // decoder geometry

  localparam int LLR_W  = 6;  // bits per llr symbol
  localparam int P_ROWS = 4;  // rows per cycle
  localparam int WT     = 2;  // circulant weight
  localparam int NB_BLK = 4;  // circulant blocks per layer
  localparam int KB_SYS = 3;  // systematic blocks, unload capable
  localparam int DEPTH  = 8;  // words per circulant memory
  localparam int ADDR_W = 3;

  ////////////////////
  // derived widths

  // memory word holds all rows of one block
  // {row P_ROWS-1 {wt1, wt0}, ..., row 0 {wt1, wt0}}
  localparam int R_SYM = P_ROWS * WT;
  localparam int BLK_W = R_SYM * LLR_W;

  // row group as seen by the row calculation units
  // {blk NB_BLK-1 {wt1, wt0}, ..., blk 0 {wt1, wt0}}
  localparam int ROW_W = NB_BLK * WT * LLR_W;

  localparam int BUS_W = NB_BLK * BLK_W;   // write, read and load buses
  localparam int HD_W  = R_SYM;            // one sign per stored symbol
  localparam int HDV_W = KB_SYS * HD_W;    // unload vector, block 0 in the lsbs

  ////////////////////
  // pipeline latencies

  localparam int RD_LAT = 3;  // rd_en sampled to o_rd_valid
  localparam int HD_LAT = 2;  // unload_en sampled to o_hd_valid

endpackage

`default_nettype wire

/* hdl/lmem_read_align.sv */
`default_nettype none

// read pipeline, block to row order and layer select
module lmem_read_align (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_rd_en,
  input  wire                        i_rd_layer,
  input  wire                        i_unload_en,
  input  wire  [lmem_pkg::BUS_W-1:0] i_fwd_data,  // block order from the fwd group
  input  wire  [lmem_pkg::BUS_W-1:0] i_bwd_data,  // block order from the bwd group
  input  wire  [lmem_pkg::HDV_W-1:0] i_hd_data,
  output logic [lmem_pkg::BUS_W-1:0] o_rd_data,   // row order
  output logic                       o_rd_valid,
  output logic [lmem_pkg::HDV_W-1:0] o_hd_data,
  output logic                       o_hd_valid
);

  import lmem_pkg::*;

  logic [RD_LAT-2:0] rd_vld_q;  // valid and layer ride along with each read
  logic [RD_LAT-2:0] rd_lyr_q;
  logic [BUS_W-1:0]  fwd_q;
  logic [BUS_W-1:0]  bwd_q;
  logic [BUS_W-1:0]  sel_blk;
  logic [BUS_W-1:0]  row_word;
  logic              hd_vld_q;

  ////////////////////
  // read path

  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_vld_q <= '0;
      rd_lyr_q <= '0;
    end else begin
      rd_vld_q <= {rd_vld_q[0], i_rd_en};      // stage 1 alongside the memories
      rd_lyr_q <= {rd_lyr_q[0], i_rd_layer};
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld_q[0]) begin  // stage 2
      fwd_q <= i_fwd_data;
      bwd_q <= i_bwd_data;
    end
  end

  assign sel_blk = rd_lyr_q[1] ? fwd_q : bwd_q;  // layer 1 reads what layer 0 wrote

  // inverse transpose
  for (genvar p = 0; p < P_ROWS; p++) begin : g_row
    for (genvar b = 0; b < NB_BLK; b++) begin : g_blk
      assign row_word[p*ROW_W + b*WT*LLR_W +: WT*LLR_W] =
        sel_blk[b*BLK_W + p*WT*LLR_W +: WT*LLR_W];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      o_rd_valid <= 1'b0;
      o_rd_data  <= '0;
    end else begin
      o_rd_valid <= rd_vld_q[1];  // stage 3
      if (rd_vld_q[1]) begin
        o_rd_data <= row_word;
      end
    end
  end

  ////////////////////
  // unload path

  always_ff @(posedge clk) begin
    if (!rst) begin
      hd_vld_q   <= 1'b0;
      o_hd_valid <= 1'b0;
      o_hd_data  <= '0;
    end else begin
      hd_vld_q   <= i_unload_en;  // sign bits registered in the memories here
      o_hd_valid <= hd_vld_q;
      if (hd_vld_q) begin
        o_hd_data <= i_hd_data;
      end
    end
  end

  a_rd_lyr : assert property (@(posedge clk) disable iff (!rst)
    o_rd_valid |-> !$isunknown($past(rd_lyr_q[1])));

endmodule

`default_nettype wire

/* hdl/lmem_top.sv */
`default_nettype none

// llr memory, forward group for layer 0 to 1, backward group for layer 1 to 0
module lmem_top (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         i_load_en,
  input  wire  [lmem_pkg::BUS_W-1:0]  i_load_data,   // block order
  input  wire                         i_wr_en,
  input  wire                         i_wr_layer,
  input  wire  [lmem_pkg::BUS_W-1:0]  i_wr_data,     // row order
  input  wire                         i_rd_en,
  input  wire                         i_rd_layer,
  input  wire  [lmem_pkg::ADDR_W-1:0] i_rd_address,
  input  wire                         i_unload_en,
  input  wire  [lmem_pkg::ADDR_W-1:0] i_unload_address,
  output logic [lmem_pkg::BUS_W-1:0]  o_rd_data,
  output logic                        o_rd_valid,
  output logic [lmem_pkg::HDV_W-1:0]  o_hd_data,
  output logic                        o_hd_valid
);

  import lmem_pkg::*;

  wire              wr_en_fwd;
  wire              wr_en_bwd;
  wire [BLK_W-1:0]  wr_blk [NB_BLK];  // transposed write words
  wire [HD_W-1:0]   hd_blk [NB_BLK];
  wire [BUS_W-1:0]  fwd_bus;
  wire [BUS_W-1:0]  bwd_bus;
  wire [HDV_W-1:0]  hd_bus;

  // layer decoded write enables
  assign wr_en_fwd = i_wr_en & ~i_wr_layer;
  assign wr_en_bwd = i_wr_en &  i_wr_layer;

  ////////////////////
  // per block memories

  for (genvar b = 0; b < NB_BLK; b++) begin : g_blk
    // row p, block b segment moves to row slot p of block word b
    for (genvar p = 0; p < P_ROWS; p++) begin : g_row
      assign wr_blk[b][p*WT*LLR_W +: WT*LLR_W] = i_wr_data[p*ROW_W + b*WT*LLR_W +: WT*LLR_W];
    end

    lmem_circ_fwd u_fwd (
      .clk          (clk),
      .rst          (rst),
      .i_wr_en      (wr_en_fwd),
      .i_wr_data    (wr_blk[b]),
      .i_rd_en      (i_rd_en),       // both groups read, layer picked later
      .i_rd_address (i_rd_address),
      .o_rd_data    (fwd_bus[b*BLK_W +: BLK_W])
    );

    lmem_circ_bwd #(
      .HAS_UNLOAD ((b < KB_SYS) ? 1 : 0)
    ) u_bwd (
      .clk              (clk),
      .rst              (rst),
      .i_load_en        (i_load_en),
      .i_load_data      (i_load_data[b*BLK_W +: BLK_W]),
      .i_wr_en          (wr_en_bwd),
      .i_wr_data        (wr_blk[b]),
      .i_rd_en          (i_rd_en),
      .i_rd_address     (i_rd_address),
      .i_unload_en      (i_unload_en),
      .i_unload_address (i_unload_address),
      .o_rd_data        (bwd_bus[b*BLK_W +: BLK_W]),
      .o_hd_data        (hd_blk[b])
    );

    if (b < KB_SYS) begin : g_hd
      assign hd_bus[b*HD_W +: HD_W] = hd_blk[b];  // systematic part only
    end
  end

  ////////////////////
  // output alignment

  lmem_read_align u_align (
    .clk         (clk),
    .rst         (rst),
    .i_rd_en     (i_rd_en),
    .i_rd_layer  (i_rd_layer),
    .i_unload_en (i_unload_en),
    .i_fwd_data  (fwd_bus),
    .i_bwd_data  (bwd_bus),
    .i_hd_data   (hd_bus),
    .o_rd_data   (o_rd_data),
    .o_rd_valid  (o_rd_valid),
    .o_hd_data   (o_hd_data),
    .o_hd_valid  (o_hd_valid)
  );

endmodule

`default_nettype wire

/* src.f */
hdl/lmem_pkg.sv
hdl/lmem_circ_fwd.sv
hdl/lmem_circ_bwd.sv
hdl/lmem_read_align.sv
hdl/lmem_top.sv
verification/lmem_tb.sv

/* verification/lmem_tb.sv */
`default_nettype none

module lmem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lmem_pkg::*;

  localparam string TEST_FILE = "verification/lmem_tests.txt";

  logic              clk;
  logic              rst;
  logic              i_load_en;
  logic [BUS_W-1:0]  i_load_data;
  logic              i_wr_en;
  logic              i_wr_layer;
  logic [BUS_W-1:0]  i_wr_data;
  logic              i_rd_en;
  logic              i_rd_layer;
  logic [ADDR_W-1:0] i_rd_address;
  logic              i_unload_en;
  logic [ADDR_W-1:0] i_unload_address;
  logic [BUS_W-1:0]  o_rd_data;
  logic              o_rd_valid;
  logic [HDV_W-1:0]  o_hd_data;
  logic              o_hd_valid;

  byte              op_code [$];  // one entry per file line with an operation
  logic [7:0]       op_field [$];
  logic [BUS_W-1:0] op_word [$];
  logic [BUS_W-1:0] exp_rd [$];   // row words still in flight
  logic [BUS_W-1:0] exp_hd [$];

  int n_mismatch  = 0;
  int n_other     = 0;
  int n_checks    = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;  // 0 until the file is read

  lmem_top DUT (.*);

  ////////////////////
  // clock and timeout

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d reads and %0d unloads never returned",
               cycle_cnt, exp_rd.size(), exp_hd.size());
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////
  // helpers

  task automatic check_value(input logic [BUS_W-1:0] actual,
                             input logic [BUS_W-1:0] expected, input string what);
    n_checks++;
    if (actual !== expected) begin
      n_mismatch++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // blank lines and lines opening with # carry no operation
  function automatic bit is_blank_or_comment(input string s);
    int i;
    for (i = 0; i < s.len(); i++) begin
      if (s[i] == "#") return 1'b1;
      if (s[i] != " " && s[i] != "\t" && s[i] != "\n" && s[i] != "\r") return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic idle_inputs();
    i_load_en   = 1'b0;
    i_wr_en     = 1'b0;
    i_rd_en     = 1'b0;
    i_unload_en = 1'b0;
  endtask

  task automatic apply_op(input byte code, input logic [7:0] fld, input logic [BUS_W-1:0] word);
    case (code)
      "L": begin
        i_load_en   = 1'b1;
        i_load_data = word;  // block order
      end
      "W": begin
        i_wr_en    = 1'b1;
        i_wr_layer = fld[0];
        i_wr_data  = word;   // row order
      end
      "R": begin
        i_rd_en      = 1'b1;
        i_rd_layer   = fld[4];     // upper digit is the layer
        i_rd_address = fld[2:0];
        exp_rd.push_back(word);
      end
      "U": begin
        i_unload_en      = 1'b1;
        i_unload_address = fld[2:0];
        exp_hd.push_back(word);
      end
      default: begin
        n_other++;
        $display("unknown operation letter %c in the test file", code);
      end
    endcase
  endtask

  ////////////////////
  // output monitor

  // sampled mid cycle, away from the registered output edge
  always @(negedge clk) begin
    if (o_rd_valid === 1'b1) begin
      if (exp_rd.size() == 0) begin
        n_other++;
        $display("read data valid at %0t with no read outstanding", $time);
      end else begin
        check_value(o_rd_data, exp_rd.pop_front(), "read word");
      end
    end
    if (o_hd_valid === 1'b1) begin
      if (exp_hd.size() == 0) begin
        n_other++;
        $display("hard decision valid at %0t with no unload outstanding", $time);
      end else begin
        check_value(BUS_W'(o_hd_data), exp_hd.pop_front(), "hard decisions");
      end
    end
  end

  ////////////////////
  // stimulus

  initial begin
    int               fd;
    int               n_read;
    string            line;
    string            op_s;
    logic [7:0]       fld;
    logic [BUS_W-1:0] word;

    rst              = 1'b0;
    i_load_data      = '0;
    i_wr_layer       = 1'b0;
    i_wr_data        = '0;
    i_rd_layer       = 1'b0;
    i_rd_address     = '0;
    i_unload_address = '0;
    idle_inputs();

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s", TEST_FILE);
      $display("Done: errors found");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (!is_blank_or_comment(line)) begin
          n_read = $sscanf(line, "%s %h %h", op_s, fld, word);
          if (n_read != 3) begin
            n_other++;
            $display("malformed test line: %s", line);
          end else begin
            op_code.push_back(op_s[0]);
            op_field.push_back(fld);
            op_word.push_back(word);
          end
        end
      end
      $fclose(fd);
      cycle_limit = 4 * op_code.size() + 50;

      repeat (10) @(posedge clk);  // reset held 10 cycles
      #1;
      rst = 1'b1;

      foreach (op_code[i]) begin
        @(posedge clk);
        #1;
        idle_inputs();
        apply_op(op_code[i], op_field[i], op_word[i]);
      end
      @(posedge clk);
      #1;
      idle_inputs();

      // drain, the cycle counter catches a lost response
      while (exp_rd.size() != 0 || exp_hd.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);  // room for a stray valid

      if (n_checks == 0) begin
        n_other++;
        $display("no output was checked");
      end
      $display("errors: %0d mismatches, %0d other, %0d checks done",
               n_mismatch, n_other, n_checks);
      if (n_mismatch + n_other == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/lmem_tests.txt */
# columns: op field word, hex. L 0 load word in block order, W layer row-order word
# R {layer,addr} expected row word, U addr expected sign bits {blk2,blk1,blk0}
# channel llrs into the backward group, addresses 0 to 7
L 0 133132131130123122121120113112111110103102101100
L 0 933932931930923922921920913912911910903902901900
L 0 233232231230223222221220213212211210203202201200
L 0 A33A32A31A30A23A22A21A20A13A12A11A10A03A02A01A00
L 0 333332331330323322321320313312311310303302301300
L 0 B33B32B31B30B23B22B21B20B13B12B11B10B03B02B01B00
L 0 433432431430423422421420413412411410403402401400
L 0 C33C32C31C30C23C22C21C20C13C12C11C10C03C02C01C00
# layer 0 reads of the loaded words, back to back, row order out
R 00 133123113103132122112102131121111101130120110100
R 01 933923913903932922912902931921911901930920910900
R 02 233223213203232222212202231221211201230220210200
R 03 A33A23A13A03A32A22A12A02A31A21A11A01A30A20A10A00
R 04 333323313303332322312302331321311301330320310300
R 05 B33B23B13B03B32B22B12B02B31B21B11B01B30B20B10B00
R 06 433423413403432422412402431421411401430420410400
R 07 C33C23C13C03C32C22C12C02C31C21C11C01C30C20C10C00
# hard decisions of the systematic blocks
U 0 550000
U 1 FFAAAA
U 5 FFAAAA
U 6 550000
# layer 0 results into the forward group, read back in layer 1
W 0 F00F01F02F03F04F05F06F07F08F09F0AF0BF0CF0DF0EF0F
W 0 E10E11E12E13E14E15E16E17E18E19E1AE1BE1CE1DE1EE1F
W 0 D20D21D22D23D24D25D26D27D28D29D2AD2BD2CD2DD2ED2F
W 0 C30C31C32C33C34C35C36C37C38C39C3AC3BC3CC3DC3EC3F
R 10 F00F01F02F03F04F05F06F07F08F09F0AF0BF0CF0DF0EF0F
R 11 E10E11E12E13E14E15E16E17E18E19E1AE1BE1CE1DE1EE1F
R 12 D20D21D22D23D24D25D26D27D28D29D2AD2BD2CD2DD2ED2F
R 13 C30C31C32C33C34C35C36C37C38C39C3AC3BC3CC3DC3EC3F
# layer 1 results overwrite backward addresses 0 and 1
W 1 72F72B72772372E72A72672272D72972572172C728724720
W 1 3CF3CB3C73C33CE3CA3C63C23CD3C93C53C13CC3C83C43C0
R 00 72F72B72772372E72A72672272D72972572172C728724720
R 01 3CF3CB3C73C33CE3CA3C63C23CD3C93C53C13CC3C83C43C0
R 10 F00F01F02F03F04F05F06F07F08F09F0AF0BF0CF0DF0EF0F
R 11 E10E11E12E13E14E15E16E17E18E19E1AE1BE1CE1DE1EE1F
# alternating layers, one read per cycle
R 02 233223213203232222212202231221211201230220210200
R 12 D20D21D22D23D24D25D26D27D28D29D2AD2BD2CD2DD2ED2F
R 03 A33A23A13A03A32A22A12A02A31A21A11A01A30A20A10A00
R 13 C30C31C32C33C34C35C36C37C38C39C3AC3BC3CC3DC3EC3F
U 0 555555
